//--- tcdm_burst.f
tcdm_burst_pkg.sv
tcdm_fifo.sv
tcdm_burst_cutter.sv
tcdm_bank_array.sv
tcdm_burst_top.sv
tcdm_burst_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -j 0 \
       -f tcdm_burst.f --top-module tcdm_burst_tb -o tcdm_burst_sim \
  && ./obj_dir/tcdm_burst_sim \
  || { echo "Simulation failed"; exit 1; }

exit 0

//--- tcdm_burst_tb.sv
/*
 * Testbench for the TCDM burst request path
 * LFSR-driven requests against a reference memory, expected responses
 * kept in order and compared at every response transfer
 */

`timescale 1ns/1ps
`default_nettype none

module tcdm_burst_tb;

  localparam int unsigned NumBanks    = tcdm_burst_pkg::NumBanks;
  localparam int unsigned MemWords    = NumBanks * tcdm_burst_pkg::NumRows;
  localparam int unsigned ClkPeriod   = 40;
  localparam logic [31:0] Seed        = 32'h7661_3f02;
  localparam logic [31:0] Taps        = 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
  localparam int unsigned NumDirReqs  = 8;
  localparam int unsigned NumRandReqs = 160;
  localparam int unsigned NumReqs     = NumDirReqs + NumRandReqs;
  localparam int unsigned WatchdogNs  = NumReqs * 40 * ClkPeriod;

  typedef logic [NumBanks-1:0][tcdm_burst_pkg::DataWidth-1:0] words_t;

  logic                                  clk_i, rst_ni;
  logic [tcdm_burst_pkg::IniIdWidth-1:0] req_ini_id_i;
  logic [tcdm_burst_pkg::AddrWidth-1:0]  req_tgt_addr_i;
  logic                                  req_wen_i;
  logic [tcdm_burst_pkg::DataWidth-1:0]  req_wdata_i;
  logic [tcdm_burst_pkg::BeWidth-1:0]    req_be_i;
  tcdm_burst_pkg::burst_t                req_burst_i;
  logic                                  req_valid_i, req_ready_o;
  logic [tcdm_burst_pkg::IniIdWidth-1:0] rsp_ini_id_o;
  logic [tcdm_burst_pkg::AddrWidth-1:0]  rsp_tgt_addr_o;
  logic                                  rsp_wen_o;
  tcdm_burst_pkg::burst_t                rsp_burst_o;
  words_t                                rsp_rdata_o;
  logic                                  rsp_valid_o, rsp_ready_i;

  logic [31:0]          ref_mem [MemWords];  // Reference copy of the banks
  tcdm_burst_pkg::rsp_t exp_q [$];           // Responses still owed, oldest first
  int unsigned          exp_count, rsp_count;
  logic [31:0]          stim_lfsr, bp_lfsr;
  logic                 bp_enable;

  tcdm_burst_top i_tcdm_burst_top (
    .clk_i, .rst_ni,
    .req_ini_id_i, .req_tgt_addr_i, .req_wen_i, .req_wdata_i, .req_be_i, .req_burst_i,
    .req_valid_i, .req_ready_o,
    .rsp_ini_id_o, .rsp_tgt_addr_o, .rsp_wen_o, .rsp_burst_o, .rsp_rdata_o,
    .rsp_valid_o, .rsp_ready_i
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ Taps) : (s >> 1);  // Galois form, shift right
  endfunction

  // One register step per bit taken
  function automatic logic [31:0] draw_bits(inout logic [31:0] state, input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits  = {bits[30:0], state[0]};
      state = lfsr_next(state);
    end
    return bits;
  endfunction

  task automatic report_mismatch(input string name, input logic [255:0] exp_val,
                                 input logic [255:0] act_val);
    $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h",
             $time, name, exp_val, act_val);
    $display("TEST FAILED");
    $fatal(1, "Wrong value on %s", name);
  endtask

  task automatic abort_run(input string msg);
    $display("At %0t ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "%s", msg);
  endtask

  // Reference words from start onward, zero in the unused slots
  function automatic words_t read_words(input int unsigned start, input int unsigned n);
    words_t words;
    words = '0;
    for (int s = 0; s < n; s++) words[s] = ref_mem[(start + s) % MemWords];
    return words;
  endfunction

  // Model of one accepted request, with the row cut applied
  task automatic expect_request();
    tcdm_burst_pkg::rsp_t e;
    int unsigned          w, n, room;
    logic [15:0]          addr2;
    w          = int'(req_tgt_addr_i >> tcdm_burst_pkg::ByteOffWidth) % MemWords;
    e          = '0;
    e.ini_id   = req_ini_id_i;
    e.tgt_addr = req_tgt_addr_i;
    e.wen      = req_wen_i;
    if (req_wen_i) begin
      for (int i = 0; i < tcdm_burst_pkg::BeWidth; i++) begin
        if (req_be_i[i]) ref_mem[w][8*i +: 8] = req_wdata_i[8*i +: 8];
      end
      exp_q.push_back(e);  // Burst field stays cleared
      exp_count++;
    end else begin
      n       = req_burst_i.isburst ? int'(req_burst_i.blen) : 1;
      room    = NumBanks - (w % NumBanks);  // Banks left in this row
      e.burst = req_burst_i;
      if (req_burst_i.isburst && n > room) begin
        e.burst.blen = tcdm_burst_pkg::BlenWidth'(room);
        e.rdata      = read_words(w, room);
        exp_q.push_back(e);
        addr2        = req_tgt_addr_i + 16'(room * tcdm_burst_pkg::BeWidth);
        e.tgt_addr   = addr2;                 // Bank 0 of the next row
        e.burst.blen = tcdm_burst_pkg::BlenWidth'(n - room);
        e.rdata      = read_words(int'(addr2 >> 2) % MemWords, n - room);
        exp_q.push_back(e);
        exp_count += 2;
      end else begin
        e.rdata = read_words(w, n);
        exp_q.push_back(e);
        exp_count++;
      end
    end
  endtask

  task automatic check_response();
    tcdm_burst_pkg::rsp_t e;
    assert (exp_q.size() != 0) else abort_run("Response arrived with nothing outstanding");
    e = exp_q.pop_front();
    rsp_count++;
    assert (rsp_ini_id_o == e.ini_id)
      else report_mismatch("rsp_ini_id_o", e.ini_id, rsp_ini_id_o);
    assert (rsp_tgt_addr_o == e.tgt_addr)
      else report_mismatch("rsp_tgt_addr_o", e.tgt_addr, rsp_tgt_addr_o);
    assert (rsp_wen_o == e.wen) else report_mismatch("rsp_wen_o", e.wen, rsp_wen_o);
    assert (rsp_burst_o == e.burst)
      else report_mismatch("rsp_burst_o", e.burst, rsp_burst_o);
    for (int s = 0; s < NumBanks; s++) begin
      assert (rsp_rdata_o[s] == e.rdata[s])
        else report_mismatch($sformatf("rsp_rdata_o[%0d]", s), e.rdata[s], rsp_rdata_o[s]);
    end
  endtask

  // Both transfers seen with values from before the edge
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (req_valid_i && req_ready_o) expect_request();
      if (rsp_valid_o && rsp_ready_i) check_response();
    end
  end

  a_rsp_hold : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o &&
      $stable({rsp_ini_id_o, rsp_tgt_addr_o, rsp_wen_o, rsp_burst_o, rsp_rdata_o})))
    else abort_run("Response valid or payload changed before it was taken");

  // Random back-pressure, ready about three cycles in four
  always @(posedge clk_i) begin
    #5;
    if (bp_enable) rsp_ready_i = (draw_bits(bp_lfsr, 2) != 0);
  end

  // Holds the request until an edge with ready, returns just after it
  task automatic send_req(input logic [2:0] id, input logic [15:0] addr, input logic wen,
                          input logic [31:0] wdata, input logic [3:0] be,
                          input logic isburst, input logic [3:0] blen);
    req_ini_id_i        = id;
    req_tgt_addr_i      = addr;
    req_wen_i           = wen;
    req_wdata_i         = wdata;
    req_be_i            = be;
    req_burst_i.isburst = isburst;
    req_burst_i.blen    = blen;
    req_valid_i         = 1'b1;
    do @(posedge clk_i); while (!req_ready_o);
    #5;
  endtask

  initial begin
    #(WatchdogNs);
    $display("Watchdog expired with %0d of %0d responses received", rsp_count, exp_count);
    $display("TEST FAILED");
    $fatal(1, "Run did not finish in time");
  end

  initial begin
    logic [31:0] kind, addr, id, wdata, be, flag, blen;
    rst_ni         = 1'b0;
    req_ini_id_i   = '0;
    req_tgt_addr_i = '0;
    req_wen_i      = 1'b0;
    req_wdata_i    = '0;
    req_be_i       = '0;
    req_burst_i    = '0;
    req_valid_i    = 1'b0;
    rsp_ready_i    = 1'b0;
    bp_enable      = 1'b0;
    stim_lfsr      = Seed;
    bp_lfsr        = Seed;
    exp_count      = 0;
    rsp_count      = 0;
    for (int i = 0; i < MemWords; i++) ref_mem[i] = '0;  // Banks clear on reset
    repeat (2) @(posedge clk_i);
    #5 rst_ni = 1'b1;
    @(posedge clk_i);
    // Idle state before the first request
    assert (!rsp_valid_o) else report_mismatch("rsp_valid_o", 0, rsp_valid_o);
    assert (req_ready_o) else report_mismatch("req_ready_o", 1, req_ready_o);
    #5 bp_enable = 1'b1;

    send_req(3'd1, 16'h0040, 1'b1, 32'h1122_3344, 4'hf, 1'b0, 4'd0);
    send_req(3'd2, 16'h0040, 1'b1, 32'haabb_ccdd, 4'b0101, 1'b0, 4'd0);  // Byte merge
    send_req(3'd3, 16'h0040, 1'b0, '0, '0, 1'b0, 4'd0);
    send_req(3'd4, 16'h0020, 1'b0, '0, '0, 1'b1, 4'd8);                  // Whole row
    send_req(3'd5, 16'h0034, 1'b0, '0, '0, 1'b1, 4'd6);                  // Cut 3 + 3
    send_req(3'd6, 16'h01fc, 1'b0, '0, '0, 1'b1, 4'd4);                  // Wraps to word 0
    send_req(3'd7, 16'h0044, 1'b1, 32'hdead_beef, 4'hf, 1'b1, 4'd3);     // One word only
    send_req(3'd0, 16'h0040, 1'b0, '0, '0, 1'b1, 4'd3);

    for (int k = 0; k < NumRandReqs; k++) begin
      kind = draw_bits(stim_lfsr, 2);
      addr = draw_bits(stim_lfsr, 16);  // Upper bits alias onto the banks
      id   = draw_bits(stim_lfsr, 3);
      if (kind == 0) begin
        wdata = draw_bits(stim_lfsr, 32);
        be    = draw_bits(stim_lfsr, 4);
        flag  = draw_bits(stim_lfsr, 1);
        blen  = draw_bits(stim_lfsr, 3);
        send_req(id[2:0], addr[15:0], 1'b1, wdata, be[3:0], flag[0], blen[3:0]);
      end else if (kind == 1) begin
        send_req(id[2:0], addr[15:0], 1'b0, '0, '0, 1'b0, 4'd0);
      end else begin
        blen = draw_bits(stim_lfsr, 3) + 1;  // Lengths 1 to 8
        send_req(id[2:0], addr[15:0], 1'b0, '0, '0, 1'b1, blen[3:0]);
      end
    end
    req_valid_i = 1'b0;

    while (rsp_count < exp_count) @(posedge clk_i);
    repeat (4) @(posedge clk_i);  // Room for a stray extra response
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- tcdm_burst_top.sv
/*
 * TCDM burst request path top level
 * Request FIFO, burst cutter, bank array and response FIFO in a chain
 */

`timescale 1ns/1ps
`default_nettype none

module tcdm_burst_top (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_ni,
  // Request port
  input  wire logic [tcdm_burst_pkg::IniIdWidth-1:0]         req_ini_id_i,
  input  wire logic [tcdm_burst_pkg::AddrWidth-1:0]          req_tgt_addr_i,
  input  wire logic                                          req_wen_i,
  input  wire logic [tcdm_burst_pkg::DataWidth-1:0]          req_wdata_i,
  input  wire logic [tcdm_burst_pkg::BeWidth-1:0]            req_be_i,
  input  wire tcdm_burst_pkg::burst_t                        req_burst_i,
  input  wire logic                                          req_valid_i,
  output logic                                               req_ready_o,
  // Response port
  output logic [tcdm_burst_pkg::IniIdWidth-1:0]              rsp_ini_id_o,
  output logic [tcdm_burst_pkg::AddrWidth-1:0]               rsp_tgt_addr_o,
  output logic                                               rsp_wen_o,
  output tcdm_burst_pkg::burst_t                             rsp_burst_o,
  output logic [tcdm_burst_pkg::NumBanks-1:0][tcdm_burst_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                                               rsp_valid_o,
  input  wire logic                                          rsp_ready_i
);

  tcdm_burst_pkg::req_t req_in, req_q;
  tcdm_burst_pkg::rsp_t rsp_d, rsp_q;
  logic                 req_q_valid, req_q_ready;
  logic                 rsp_d_valid, rsp_d_ready;

  // Cutter to bank array
  logic [tcdm_burst_pkg::IniIdWidth-1:0] cut_ini_id;
  logic [tcdm_burst_pkg::AddrWidth-1:0]  cut_tgt_addr;
  logic                                  cut_wen;
  logic [tcdm_burst_pkg::DataWidth-1:0]  cut_wdata;
  logic [tcdm_burst_pkg::BeWidth-1:0]    cut_be;
  tcdm_burst_pkg::burst_t                cut_burst;
  logic                                  cut_valid, cut_ready;

  always_comb begin
    req_in.ini_id   = req_ini_id_i;
    req_in.tgt_addr = req_tgt_addr_i;
    req_in.wen      = req_wen_i;
    req_in.wdata    = req_wdata_i;
    req_in.be       = req_be_i;
    req_in.burst    = req_burst_i;
  end

  tcdm_fifo #(
    .payload_t (tcdm_burst_pkg::req_t),
    .Depth     (tcdm_burst_pkg::ReqFifoDepth)
  ) i_req_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_data_i   (req_in),
    .in_valid_i  (req_valid_i),
    .in_ready_o  (req_ready_o),
    .out_data_o  (req_q),
    .out_valid_o (req_q_valid),
    .out_ready_i (req_q_ready)
  );

  tcdm_burst_cutter i_burst_cutter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_ini_id_i   (req_q.ini_id),
    .req_tgt_addr_i (req_q.tgt_addr),
    .req_wen_i      (req_q.wen),
    .req_wdata_i    (req_q.wdata),
    .req_be_i       (req_q.be),
    .req_burst_i    (req_q.burst),
    .req_valid_i    (req_q_valid),
    .req_ready_o    (req_q_ready),
    .req_ini_id_o   (cut_ini_id),
    .req_tgt_addr_o (cut_tgt_addr),
    .req_wen_o      (cut_wen),
    .req_wdata_o    (cut_wdata),
    .req_be_o       (cut_be),
    .req_burst_o    (cut_burst),
    .req_valid_o    (cut_valid),
    .req_ready_i    (cut_ready)
  );

  tcdm_bank_array i_bank_array (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_ini_id_i   (cut_ini_id),
    .req_tgt_addr_i (cut_tgt_addr),
    .req_wen_i      (cut_wen),
    .req_wdata_i    (cut_wdata),
    .req_be_i       (cut_be),
    .req_burst_i    (cut_burst),
    .req_valid_i    (cut_valid),
    .req_ready_o    (cut_ready),
    .rsp_o          (rsp_d),
    .rsp_valid_o    (rsp_d_valid),
    .rsp_ready_i    (rsp_d_ready)
  );

  // Registers the response, one cycle after the bank access
  tcdm_fifo #(
    .payload_t (tcdm_burst_pkg::rsp_t),
    .Depth     (tcdm_burst_pkg::RspFifoDepth)
  ) i_rsp_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_data_i   (rsp_d),
    .in_valid_i  (rsp_d_valid),
    .in_ready_o  (rsp_d_ready),
    .out_data_o  (rsp_q),
    .out_valid_o (rsp_valid_o),
    .out_ready_i (rsp_ready_i)
  );

  assign rsp_ini_id_o   = rsp_q.ini_id;
  assign rsp_tgt_addr_o = rsp_q.tgt_addr;
  assign rsp_wen_o      = rsp_q.wen;
  assign rsp_burst_o    = rsp_q.burst;
  assign rsp_rdata_o    = rsp_q.rdata;

endmodule

`default_nettype wire

//--- tcdm_bank_array.sv
/*
 * Word-interleaved bank array
 * Word address modulo NumBanks picks the bank, so a burst inside one
 * row reads one word from each bank in a single access
 */

`timescale 1ns/1ps
`default_nettype none

module tcdm_bank_array (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  // Request from the cutter
  input  wire logic [tcdm_burst_pkg::IniIdWidth-1:0] req_ini_id_i,
  input  wire logic [tcdm_burst_pkg::AddrWidth-1:0]  req_tgt_addr_i,
  input  wire logic                                  req_wen_i,
  input  wire logic [tcdm_burst_pkg::DataWidth-1:0]  req_wdata_i,
  input  wire logic [tcdm_burst_pkg::BeWidth-1:0]    req_be_i,
  input  wire tcdm_burst_pkg::burst_t                req_burst_i,
  input  wire logic                                  req_valid_i,
  output logic                                       req_ready_o,
  // Response to the response FIFO
  output tcdm_burst_pkg::rsp_t                       rsp_o,
  output logic                                       rsp_valid_o,
  input  wire logic                                  rsp_ready_i
);

  // One row index per bank, one word per entry
  logic [tcdm_burst_pkg::DataWidth-1:0] mem_q
    [tcdm_burst_pkg::NumBanks][tcdm_burst_pkg::NumRows];

  logic [tcdm_burst_pkg::BankIdxWidth-1:0] bank_idx;
  logic [tcdm_burst_pkg::RowIdxWidth-1:0]  row_idx;
  logic [tcdm_burst_pkg::BlenWidth-1:0]    n_words;   // Slots to fill
  logic [tcdm_burst_pkg::BankIdxWidth-1:0] rd_bank [tcdm_burst_pkg::NumBanks];
  logic                                    req_fire;

  assign bank_idx = req_tgt_addr_i[tcdm_burst_pkg::AddrMemWidth-1:tcdm_burst_pkg::ByteOffWidth];
  assign row_idx  = req_tgt_addr_i[tcdm_burst_pkg::AddrMemWidth+tcdm_burst_pkg::RowIdxWidth-1:
                                   tcdm_burst_pkg::AddrMemWidth];  // Upper bits wrap

  // Single access, so accept only when the response has room
  assign req_ready_o = rsp_ready_i;
  assign rsp_valid_o = req_valid_i;
  assign req_fire    = req_valid_i & req_ready_o;

  // Writes read nothing back, single reads fill slot 0
  assign n_words = req_wen_i           ? '0 :
                   req_burst_i.isburst ? req_burst_i.blen :
                                         tcdm_burst_pkg::BlenWidth'(1);

  always_comb begin
    rsp_o.ini_id   = req_ini_id_i;
    rsp_o.tgt_addr = req_tgt_addr_i;
    rsp_o.wen      = req_wen_i;
    rsp_o.burst    = req_burst_i;
    for (int s = 0; s < tcdm_burst_pkg::NumBanks; s++) begin
      // Consecutive banks of the same row
      rd_bank[s] = bank_idx + tcdm_burst_pkg::BankIdxWidth'(s);
      if (s < int'(n_words)) begin
        rsp_o.rdata[s] = mem_q[rd_bank[s]][row_idx];  // Contents before the edge
      end else begin
        rsp_o.rdata[s] = '0;
      end
    end
  end

  // Memory clears on reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int b = 0; b < tcdm_burst_pkg::NumBanks; b++) begin
        for (int r = 0; r < tcdm_burst_pkg::NumRows; r++) begin
          mem_q[b][r] <= '0;
        end
      end
    end else if (req_fire && req_wen_i) begin
      for (int i = 0; i < tcdm_burst_pkg::BeWidth; i++) begin
        if (req_be_i[i]) begin
          mem_q[bank_idx][row_idx][8*i +: 8] <= req_wdata_i[8*i +: 8];  // Byte merge
        end
      end
    end
  end

  // Cutter must have split any row-crossing burst upstream
  a_burst_in_row : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_fire && !req_wen_i && req_burst_i.isburst)
      |-> ((bank_idx + req_burst_i.blen) <= tcdm_burst_pkg::NumBanks))
    else $error("Accepted read burst crosses a bank row");

endmodule

`default_nettype wire

//--- tcdm_burst_cutter.sv
/*
 * Burst cutter
 * Splits a read burst that runs past the last bank of a row into two
 * bursts, the second one starting at bank 0 of the next row
 * Writes lose their burst field and pass as single words
 */

`timescale 1ns/1ps
`default_nettype none

module tcdm_burst_cutter (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  // Request in, from the request FIFO
  input  wire logic [tcdm_burst_pkg::IniIdWidth-1:0] req_ini_id_i,
  input  wire logic [tcdm_burst_pkg::AddrWidth-1:0]  req_tgt_addr_i,
  input  wire logic                                  req_wen_i,
  input  wire logic [tcdm_burst_pkg::DataWidth-1:0]  req_wdata_i,
  input  wire logic [tcdm_burst_pkg::BeWidth-1:0]    req_be_i,
  input  wire tcdm_burst_pkg::burst_t                req_burst_i,
  input  wire logic                                  req_valid_i,
  output logic                                       req_ready_o,
  // Request out, to the bank array
  output logic [tcdm_burst_pkg::IniIdWidth-1:0]      req_ini_id_o,
  output logic [tcdm_burst_pkg::AddrWidth-1:0]       req_tgt_addr_o,
  output logic                                       req_wen_o,
  output logic [tcdm_burst_pkg::DataWidth-1:0]       req_wdata_o,
  output logic [tcdm_burst_pkg::BeWidth-1:0]         req_be_o,
  output tcdm_burst_pkg::burst_t                     req_burst_o,
  output logic                                       req_valid_o,
  input  wire logic                                  req_ready_i
);

  typedef enum logic {
    Bypass,    // Pass through, or first half of a cut
    BurstCut   // Second half of a cut
  } cutter_state_e;

  cutter_state_e state_d, state_q;

  // Second half, captured while the first half goes out
  logic [tcdm_burst_pkg::IniIdWidth-1:0]   cut_ini_id_q;
  logic [tcdm_burst_pkg::AddrWidth-1:0]    cut_tgt_addr_q;
  logic [tcdm_burst_pkg::BlenWidth-1:0]    cut_blen_q;
  logic                                    cut_en;

  logic [tcdm_burst_pkg::BankIdxWidth-1:0] bank_off;
  logic [tcdm_burst_pkg::BlenWidth-1:0]    room;       // Words left in the row
  logic [tcdm_burst_pkg::BlenWidth-1:0]    rem_len;
  logic [tcdm_burst_pkg::AddrWidth-1:0]    cut_addr;
  logic                                    need_cut;
  logic [tcdm_burst_pkg::BankIdxWidth-1:0] out_bank_off;

  assign bank_off = req_tgt_addr_i[tcdm_burst_pkg::AddrMemWidth-1:tcdm_burst_pkg::ByteOffWidth];
  assign room     = tcdm_burst_pkg::BlenWidth'(tcdm_burst_pkg::NumBanks)
                  - tcdm_burst_pkg::BlenWidth'(bank_off);
  assign rem_len  = req_burst_i.blen - room;
  // Lands on bank 0 of the next row, wraps with the address
  assign cut_addr = req_tgt_addr_i
                  + (tcdm_burst_pkg::AddrWidth'(room) << tcdm_burst_pkg::ByteOffWidth);
  assign need_cut = req_burst_i.isburst & ~req_wen_i & (req_burst_i.blen > room);

  always_comb begin
    // Bypass by default
    state_d        = state_q;
    cut_en         = 1'b0;
    req_ini_id_o   = req_ini_id_i;
    req_tgt_addr_o = req_tgt_addr_i;
    req_wen_o      = req_wen_i;
    req_wdata_o    = req_wdata_i;
    req_be_o       = req_be_i;
    req_burst_o    = req_burst_i;
    req_valid_o    = req_valid_i;
    req_ready_o    = req_ready_i;

    unique case (state_q)
      Bypass: begin
        if (req_wen_i) begin
          req_burst_o = '0;             // No write bursts
        end else if (need_cut) begin
          req_burst_o.blen = room;      // First half fills the row
          req_ready_o      = 1'b0;      // Input stays until the second half
          if (req_valid_i && req_ready_i) begin
            state_d = BurstCut;
            cut_en  = 1'b1;
          end
        end
      end
      BurstCut: begin
        // Remainder of the burst, read only
        req_ini_id_o        = cut_ini_id_q;   // Same initiator
        req_tgt_addr_o      = cut_tgt_addr_q;
        req_wen_o           = 1'b0;
        req_wdata_o         = '0;
        req_be_o            = '0;
        req_burst_o.isburst = 1'b1;
        req_burst_o.blen    = cut_blen_q;
        req_valid_o         = 1'b1;
        req_ready_o         = req_ready_i;    // Pop together with the second half
        if (req_ready_i) state_d = Bypass;
      end
      default: state_d = Bypass;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Bypass;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cut_en) begin
      cut_ini_id_q   <= req_ini_id_i;
      cut_tgt_addr_q <= cut_addr;
      cut_blen_q     <= rem_len;
    end
  end

  assign out_bank_off =
    req_tgt_addr_o[tcdm_burst_pkg::AddrMemWidth-1:tcdm_burst_pkg::ByteOffWidth];

  // Only one cut per burst is possible
  a_cut_len : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == BurstCut) |-> (cut_blen_q <= tcdm_burst_pkg::BlenWidth'(tcdm_burst_pkg::NumBanks)))
    else $error("Remaining burst length above bank count");

  a_out_in_row : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_valid_o && !req_wen_o && req_burst_o.isburst)
      |-> ((out_bank_off + req_burst_o.blen) <= tcdm_burst_pkg::NumBanks))
    else $error("Cutter output burst crosses a bank row");

endmodule

`default_nettype wire

//--- tcdm_fifo.sv
/*
 * Valid/ready FIFO
 * Circular buffer with a generic payload type, output read straight
 * from storage, so data appears the cycle after the push
 */

`timescale 1ns/1ps
`default_nettype none

module tcdm_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned Depth     = 2
) (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire payload_t in_data_i,
  input  wire logic     in_valid_i,
  output logic          in_ready_o,
  output payload_t      out_data_o,
  output logic          out_valid_o,
  input  wire logic     out_ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  payload_t            mem_q [Depth];
  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                full, push, pop;

  assign full        = (count_q == CntWidth'(Depth));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];       // No fall-through
  assign in_ready_o  = ~full | out_ready_i;   // Full slot frees on a pop
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        // Wrap at Depth, which need not be a power of two
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

  a_count_in_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= CntWidth'(Depth))
    else $error("FIFO occupancy above depth");

  // Head entry must hold until it is taken
  a_out_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o)))
    else $error("FIFO output changed while stalled");

endmodule

`default_nettype wire

//--- tcdm_burst_pkg.sv
/*
 * TCDM burst request path definitions
 * Sizes of the banked scratchpad, the burst descriptor and the
 * request and response payloads shared by the FIFOs, cutter and banks
 */

`default_nettype none

package tcdm_burst_pkg;

  // Initiators sharing the request port
  localparam int unsigned NumIn        = 8;
  localparam int unsigned IniIdWidth   = $clog2(NumIn);  // 3 bits

  // Memory geometry
  localparam int unsigned NumBanks     = 8;
  localparam int unsigned NumRows      = 16;             // Words per bank
  localparam int unsigned AddrWidth    = 16;             // Byte address
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned BeWidth      = DataWidth / 8;
  localparam int unsigned ByteOffWidth = $clog2(BeWidth);
  localparam int unsigned BankIdxWidth = $clog2(NumBanks);
  localparam int unsigned RowIdxWidth  = $clog2(NumRows);
  // Byte offset plus bank index, one bank row
  localparam int unsigned AddrMemWidth = ByteOffWidth + BankIdxWidth;

  // Burst length 0 to NumBanks
  localparam int unsigned BlenWidth    = $clog2(NumBanks + 1);

  // Buffering on both sides of the banks
  localparam int unsigned ReqFifoDepth = 2;
  localparam int unsigned RspFifoDepth = 2;

  typedef struct packed {
    logic                 isburst;
    logic [BlenWidth-1:0] blen;     // Words in the burst
  } burst_t;

  typedef struct packed {
    logic [IniIdWidth-1:0] ini_id;
    logic [AddrWidth-1:0]  tgt_addr;
    logic                  wen;
    logic [DataWidth-1:0]  wdata;   // Single word, no write bursts
    logic [BeWidth-1:0]    be;
    burst_t                burst;
  } req_t;

  typedef struct packed {
    logic [IniIdWidth-1:0]               ini_id;
    logic [AddrWidth-1:0]                tgt_addr;  // Address of the first word
    logic                                wen;
    burst_t                              burst;
    logic [NumBanks-1:0][DataWidth-1:0]  rdata;     // Slot 0 holds the first word
  } rsp_t;

endpackage

`default_nettype wire
